//--- sim/raster_checker.sv
`timescale 1ns/1ps

module raster_checker import vic_pkg::*; (
   input logic       clk_dot4x,
   input logic       rst,
   input chip_t      chip,
   input reg_wr_t    reg_wr,
   input logic       pixel_strobe,
   input position_t  pos,
   input logic [9:0] sprite_raster_x,
   input logic [8:0] raster_line_d,
   input logic       irq,
   input logic       hsync,
   input logic       vsync
);

   int unsigned clk_count;
   int          check_count;
   int          error_count;
   logic [9:0]  m_x;
   logic [9:0]  m_xpos;
   logic [8:0]  m_line;
   logic [8:0]  m_line_prev;
   logic [9:0]  m_sprite_x;
   logic [8:0]  m_cmp;
   logic        m_flag;
   logic        m_en;
   logic        m_irq;
   logic        m_hs;
   logic        m_vs;
   logic        flag_n;
   logic        en_n;
   logic        wr;

   function automatic logic [9:0] ref_raster_x(chip_t c, logic [9:0] x);
      return (x == X_MAX[c]) ? 10'd0 : x + 10'd1;
   endfunction

   function automatic logic [8:0] ref_line(chip_t c, logic [9:0] x, logic [8:0] line);
      if (x != X_MAX[c]) return line;
      return (line == Y_MAX[c]) ? 9'd0 : line + 9'd1;
   endfunction

   function automatic logic [8:0] ref_line_prev(chip_t c, logic [8:0] line);
      return (line == 9'd0) ? Y_MAX[c] : line - 9'd1;
   endfunction

   // xpos jumps keyed on bus cycle and pixel within the cycle
   function automatic logic [9:0] ref_xpos(chip_t c, logic [9:0] x, logic [9:0] xpos);
      logic [6:0] cyc;
      logic [2:0] b;
      cyc = x[9:3];
      b   = x[2:0];
      if (x == X_MAX[c]) return XPOS_START[c];
      if (x == 10'd0) return (c == CHIP6567R8 || c == CHIP6567R56A) ? 10'h19d : 10'h195;
      if (cyc == 7'd12 && b == 3'd3) return 10'd0;
      if (c == CHIP6567R8 && ((cyc == 7'd60 && b == 3'd7) ||
                              (cyc == 7'd61 && (b == 3'd3 || b == 3'd7)))) return 10'h184;
      return xpos + 10'd1;
   endfunction

   function automatic logic [9:0] ref_sprite_x(chip_t c, logic [9:0] s);
      return (s == X_MAX[c]) ? 10'd0 : s + 10'd1;
   endfunction

   function automatic logic ref_hsync(chip_t c, logic [9:0] xpos);
      return (xpos >= HSYNC_START[c]) && (xpos < HSYNC_END[c]);
   endfunction

   function automatic logic ref_vsync(chip_t c, logic [8:0] line);
      return (line >= VSYNC_START[c]) && (line < VSYNC_START[c] + VSYNC_LINES);
   endfunction

   // a match on a new line beats a status clear in the same clock
   function automatic logic ref_flag(logic flag, logic clear, logic match);
      if (match) return 1'b1;
      return clear ? 1'b0 : flag;
   endfunction

   task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      end
   endtask

   initial begin
      check_count = 0;
      error_count = 0;
   end

   // model state, advanced on the clock where the pixel strobe is due
   always @(posedge clk_dot4x) begin
      if (rst) begin
         clk_count   <= 0;
         m_x         <= 10'd0;
         m_line      <= 9'd0;
         m_line_prev <= 9'd0;
         m_xpos      <= XPOS_START[chip];
         m_sprite_x  <= SPRITE_X_START[chip];
         m_cmp       <= 9'd0;
         m_flag      <= 1'b0;
         m_en        <= 1'b0;
         m_irq       <= 1'b0;
         m_hs        <= 1'b0;
         m_vs        <= 1'b0;
      end else begin
         clk_count <= clk_count + 1;
         if (clk_count % 4 == 3) begin
            m_x        <= ref_raster_x(chip, m_x);
            m_line     <= ref_line(chip, m_x, m_line);
            m_xpos     <= ref_xpos(chip, m_x, m_xpos);
            m_sprite_x <= ref_sprite_x(chip, m_sprite_x);
         end
         wr     = reg_wr.strobe;
         flag_n = ref_flag(m_flag, wr && reg_wr.addr == 6'h19 && reg_wr.data.raw[0],
                           (m_line != m_line_prev) && (m_line == m_cmp));
         en_n   = (wr && reg_wr.addr == 6'h1a) ? reg_wr.data.raw[0] : m_en;
         m_flag      <= flag_n;
         m_en        <= en_n;
         m_irq       <= flag_n && en_n;
         m_line_prev <= m_line;
         if (wr && reg_wr.addr == 6'h11) m_cmp[8] <= reg_wr.data.ctrl1.raster8;
         if (wr && reg_wr.addr == 6'h12) m_cmp[7:0] <= reg_wr.data.raw;
         m_hs <= ref_hsync(chip, m_xpos);
         m_vs <= ref_vsync(chip, m_line);
      end
   end

   // outputs are stable at the falling edge
   always @(negedge clk_dot4x) begin
      if (!rst) begin
         check_value("pixel_strobe", 32'(pixel_strobe), 32'(clk_count % 4 == 3));
         check_value("raster_x", 32'(pos.raster_x), 32'(m_x));
         check_value("xpos", 32'(pos.xpos), 32'(m_xpos));
         check_value("raster_line", 32'(pos.raster_line), 32'(m_line));
         check_value("sprite_raster_x", 32'(sprite_raster_x), 32'(m_sprite_x));
         check_value("irq", 32'(irq), 32'(m_irq));
         check_value("hsync", 32'(hsync), 32'(m_hs));
         check_value("vsync", 32'(vsync), 32'(m_vs));
         // from cycle 2 on the delayed line has caught up
         if (m_x >= 10'd16) begin
            check_value("raster_line_d", 32'(raster_line_d), 32'(m_line));
         end else begin
            check_count++;
            if (raster_line_d !== m_line && raster_line_d !== ref_line_prev(chip, m_line)) begin
               error_count++;
               $display("ERROR at %0t: raster_line_d is %0d, over one line behind %0d",
                        $time, raster_line_d, m_line);
            end
         end
      end
   end

endmodule

//--- sim/tb_vic_raster.sv
`timescale 1ns/1ps

module tb_vic_raster import vic_pkg::*; ();

   logic       clk_dot4x;
   logic       rst;
   chip_t      chip;
   reg_wr_t    reg_wr;
   logic       pixel_strobe;
   position_t  pos;
   logic [9:0] sprite_raster_x;
   logic [8:0] raster_line_d;
   logic       irq;
   logic       hsync;
   logic       vsync;
   int         seed;
   int         timeout_count;

   vic_raster_top i_dut (
      .clk_dot4x       (clk_dot4x),
      .rst             (rst),
      .chip            (chip),
      .reg_wr          (reg_wr),
      .pixel_strobe    (pixel_strobe),
      .pos             (pos),
      .sprite_raster_x (sprite_raster_x),
      .raster_line_d   (raster_line_d),
      .irq             (irq),
      .hsync           (hsync),
      .vsync           (vsync)
   );

   raster_checker i_checker (.*);

   initial begin
      clk_dot4x = 1'b0;
      forever #10 clk_dot4x = ~clk_dot4x;
   end

   // chip is only changed while rst is high
   task automatic apply_reset(input chip_t c);
      @(posedge clk_dot4x);
      rst           <= 1'b1;
      chip          <= c;
      reg_wr.strobe <= 1'b0;
      repeat (16) @(posedge clk_dot4x);
      rst <= 1'b0;
   endtask

   task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
      @(posedge clk_dot4x);
      reg_wr.strobe   <= 1'b1;
      reg_wr.addr     <= addr;
      reg_wr.data.raw <= data;
      @(posedge clk_dot4x);
      reg_wr.strobe <= 1'b0;
   endtask

   task automatic wait_irq(input logic level, input int limit, input string what);
      int n;
      n = 0;
      @(negedge clk_dot4x);
      while (irq !== level && n < limit) begin
         @(negedge clk_dot4x);
         n++;
      end
      if (irq !== level) begin
         timeout_count++;
         $display("timeout after %0d clocks, %s", n, what);
      end
   endtask

   task automatic wait_line(input logic [8:0] line, input int limit, input string what);
      int n;
      n = 0;
      @(negedge clk_dot4x);
      while (pos.raster_line !== line && n < limit) begin
         @(negedge clk_dot4x);
         n++;
      end
      if (pos.raster_line !== line) begin
         timeout_count++;
         $display("timeout after %0d clocks, %s", n, what);
      end
   endtask

   task automatic run_chip(input chip_t c);
      logic [31:0] rnd;
      logic [8:0]  cmp;
      logic [8:0]  cmp_next;
      int          cmp_int;
      int          frame_clocks;
      frame_clocks = 4 * (int'(X_MAX[c]) + 1) * (int'(Y_MAX[c]) + 1);
      apply_reset(c);
      rnd      = $random(seed);
      cmp_int  = int'(rnd[15:0]) % (int'(Y_MAX[c]) + 1);
      cmp      = cmp_int[8:0];
      cmp_next = (cmp == Y_MAX[c]) ? 9'd0 : cmp + 9'd1;
      $display("chip %s, raster compare %0d", c.name(), cmp);
      write_reg(6'h11, {cmp[8], rnd[30:24]});
      write_reg(6'h12, cmp[7:0]);
      rnd = $random(seed);
      write_reg(6'h1a, rnd[7:0] | 8'h01);
      // unused address must leave the compare value and the enable alone
      write_reg(6'h20, {~cmp[7:1], 1'b0});
      wait_irq(1'b1, 2 * frame_clocks, "irq never rose at the compare line");
      write_reg(6'h19, rnd[15:8] | 8'h01);
      wait_irq(1'b0, 8, "irq stayed high after the status clear");
      write_reg(6'h1a, rnd[23:16] & 8'hfe);
      // finish the frame with the interrupt masked
      wait_line(Y_MAX[c], 2 * frame_clocks, "last line of the frame never came");
      wait_line(9'd0, 2 * frame_clocks, "raster line did not wrap to 0");
      // the compare line sets the flag again while irq has to stay low
      wait_line(cmp, 2 * frame_clocks, "compare line never came back");
      wait_line(cmp_next, 2 * frame_clocks, "line after the compare line never came");
   endtask

   initial begin
      seed          = 32'hf071;
      timeout_count = 0;
      rst           = 1'b1;
      chip          = CHIP6567R8;
      reg_wr        = '0;
      run_chip(CHIP6567R8);
      run_chip(CHIP6567R56A);
      run_chip(CHIP6569);
      run_chip(CHIPUNUSED);
      $display("checks %0d, value errors %0d, timeouts %0d",
               i_checker.check_count, i_checker.error_count, timeout_count);
      if (i_checker.error_count == 0 && timeout_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- source/dot_timing.sv
`timescale 1ns/1ps

module dot_timing import vic_pkg::*; (
   input  logic    clk_dot4x,
   input  logic    rst,
   input  chip_t   chip,
   output timing_t timing
);

   logic [1:0] sub_dot;
   logic [4:0] phase;
   logic [6:0] cycle_num;
   logic [6:0] cycle_last;
   logic       pixel;
   logic       phi;
   logic       phase_start;

   assign cycle_last = CYCLES[chip] - 7'd1;

   // sub-dot and phase counters run free, both restart together on reset
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         sub_dot <= 2'd0;
         phase   <= 5'd0;
      end else begin
         sub_dot <= sub_dot + 2'd1;
         phase   <= phase + 5'd1;
      end
   end

   // strobes are registered off the counters, so each is one clock late.
   // pixel fires at phase 3, 7, .., 31 and phase_start at 1 and 17
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         pixel       <= 1'b0;
         phi         <= 1'b0;
         phase_start <= 1'b0;
      end else begin
         pixel       <= (sub_dot == 2'd2);
         phi         <= phase[4];
         phase_start <= (phase[3:0] == 4'd0);
      end
   end

   // bus cycle advances with the last pixel of the cycle
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         cycle_num <= 7'd0;
      end else if (phase == 5'd31) begin
         if (cycle_num == cycle_last) begin
            cycle_num <= 7'd0;
         end else begin
            cycle_num <= cycle_num + 7'd1;
         end
      end
   end

   assign timing.pixel       = pixel;
   assign timing.phi         = phi;
   assign timing.phase_start = phase_start;
   assign timing.cycle_num   = cycle_num;

   // raster and sprite logic act on both strobes, they must never be back to back
   a_strobe_spacing: assert property (@(posedge clk_dot4x) disable iff (rst)
      (pixel || phase_start) |=> !(pixel || phase_start));

endmodule

//--- source/raster.sv
`timescale 1ns/1ps

module raster import vic_pkg::*; (
   input  logic       clk_dot4x,
   input  logic       rst,
   input  chip_t      chip,
   input  timing_t    timing,
   output position_t  pos,
   output logic [9:0] sprite_raster_x,
   output logic [8:0] raster_line_d
);

   logic       start_of_line;
   logic       start_of_frame;
   logic [2:0] cycle_bit;
   logic [9:0] x_max;
   logic [8:0] y_max;
   logic [9:0] xpos_start;
   logic [9:0] xpos_next;
   logic       r8_hold;

   // pixel number within the bus cycle
   assign cycle_bit = pos.raster_x[2:0];

   assign x_max      = X_MAX[chip];
   assign y_max      = Y_MAX[chip];
   assign xpos_start = XPOS_START[chip];

   // R8 only, last pixel of cycle 60 and pixels 3 and 7 of cycle 61
   assign r8_hold = (chip == CHIP6567R8) &&
                    ((timing.cycle_num == 7'd60 && cycle_bit == 3'd7) ||
                     (timing.cycle_num == 7'd61 && (cycle_bit == 3'd3 || cycle_bit == 3'd7)));

   // xpos inside a line, with the chip specific jumps
   always_comb begin
      xpos_next = pos.xpos + 10'd1;
      if (timing.cycle_num == 7'd0 && cycle_bit == 3'd0) begin
         // one past the start value, 0x19d or 0x195
         xpos_next = xpos_start + 10'd1;
      end else if (timing.cycle_num == 7'd12 && cycle_bit == 3'd3) begin
         xpos_next = 10'd0;
      end else if (r8_hold) begin
         xpos_next = XPOS_R8_HOLD;
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         pos.raster_x    <= 10'd0;
         pos.raster_line <= 9'd0;
         pos.xpos        <= xpos_start;
         sprite_raster_x <= SPRITE_X_START[chip];
         raster_line_d   <= 9'd0;
         start_of_line   <= 1'b0;
         start_of_frame  <= 1'b0;
      end else begin
         // delayed line catches up in the phi high half
         if (timing.phi && timing.phase_start) begin
            if (start_of_line) begin
               raster_line_d <= raster_line_d + 9'd1;
               start_of_line <= 1'b0;
            end else if (start_of_frame && timing.cycle_num == 7'd1) begin
               raster_line_d  <= 9'd0;
               start_of_frame <= 1'b0;
            end
         end

         if (timing.pixel) begin
            if (pos.raster_x < x_max) begin
               pos.raster_x <= pos.raster_x + 10'd1;
               pos.xpos     <= xpos_next;
            end else begin
               // end of line
               pos.raster_x <= 10'd0;
               pos.xpos     <= xpos_start;
               if (pos.raster_line < y_max) begin
                  pos.raster_line <= pos.raster_line + 9'd1;
                  start_of_line   <= 1'b1;
               end else begin
                  pos.raster_line <= 9'd0;
                  start_of_frame  <= 1'b1;
               end
            end

            if (sprite_raster_x < x_max) begin
               sprite_raster_x <= sprite_raster_x + 10'd1;
            end else begin
               sprite_raster_x <= 10'd0;
            end
         end
      end
   end

   // raster_x stays inside the line of the selected chip
   a_raster_x_max: assert property (@(posedge clk_dot4x) disable iff (rst)
      pos.raster_x <= x_max);

   // cycle counter in dot_timing must track raster_x on every pixel
   a_cycle_align: assert property (@(posedge clk_dot4x) disable iff (rst)
      timing.pixel |-> (timing.cycle_num == pos.raster_x[9:3]));

endmodule

//--- source/raster_irq.sv
`timescale 1ns/1ps

module raster_irq import vic_pkg::*; (
   input  logic      clk_dot4x,
   input  logic      rst,
   input  position_t pos,
   input  reg_wr_t   reg_wr,
   output logic      irq
);

   logic [8:0] compare;
   logic [8:0] line_prev;
   logic       flag;
   logic       flag_next;
   logic       enable;
   logic       enable_next;
   logic       line_match;
   logic       wr_ctrl1;
   logic       wr_raster;
   logic       wr_status;
   logic       wr_enable;

   assign wr_ctrl1  = reg_wr.strobe && (reg_wr.addr == ADDR_CTRL1);
   assign wr_raster = reg_wr.strobe && (reg_wr.addr == ADDR_RASTER);
   assign wr_status = reg_wr.strobe && (reg_wr.addr == ADDR_IRQ_STATUS);
   assign wr_enable = reg_wr.strobe && (reg_wr.addr == ADDR_IRQ_ENABLE);

   // only the first clock of a new line counts as a match
   assign line_match = (pos.raster_line != line_prev) && (pos.raster_line == compare);

   always_comb begin
      flag_next = flag;
      if (wr_status && reg_wr.data.raw[0]) begin
         flag_next = 1'b0;
      end
      // a new match wins over a clear in the same clock
      if (line_match) begin
         flag_next = 1'b1;
      end
      enable_next = wr_enable ? reg_wr.data.raw[0] : enable;
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         compare   <= 9'd0;
         line_prev <= 9'd0;
         flag      <= 1'b0;
         enable    <= 1'b0;
         irq       <= 1'b0;
      end else begin
         line_prev <= pos.raster_line;
         flag      <= flag_next;
         enable    <= enable_next;
         irq       <= flag_next && enable_next;
         if (wr_ctrl1) begin
            compare[8] <= reg_wr.data.ctrl1.raster8;
         end
         if (wr_raster) begin
            compare[7:0] <= reg_wr.data.raw;
         end
      end
   end

   // a masked source must never reach the cpu
   a_irq_masked: assert property (@(posedge clk_dot4x) disable iff (rst)
      irq |-> enable);

endmodule

//--- source/vic_pkg.sv
package vic_pkg;

   // chip variants, the unused code runs with 6569 timing
   typedef enum logic [1:0] {
      CHIP6567R8   = 2'd0,
      CHIP6567R56A = 2'd1,
      CHIP6569     = 2'd2,
      CHIPUNUSED   = 2'd3
   } chip_t;

   // per-chip tables, indexed by chip code
   localparam logic [9:0] X_MAX [4] = '{10'd519, 10'd511, 10'd503, 10'd503};
   localparam logic [8:0] Y_MAX [4] = '{9'd262, 9'd261, 9'd311, 9'd311};
   localparam logic [6:0] CYCLES [4] = '{7'd65, 7'd64, 7'd63, 7'd63};

   // xpos value at reset and at the start of every line
   localparam logic [9:0] XPOS_START [4] = '{10'h19c, 10'h19c, 10'h194, 10'h194};

   // first cycle where sprite #0 may pull ba low lands on sprite_raster_x == 0
   localparam logic [9:0] SPRITE_X_START [4] = '{10'd80, 10'd72, 10'd72, 10'd72};

   // the R8 holds xpos here for a few pixels near the end of the line
   localparam logic [9:0] XPOS_R8_HOLD = 10'h184;

   // sync windows, hsync on xpos and vsync on raster line
   localparam logic [9:0] HSYNC_START [4] = '{10'h1a0, 10'h1a0, 10'h198, 10'h198};
   localparam logic [9:0] HSYNC_END [4]   = '{10'h1d0, 10'h1d0, 10'h1c8, 10'h1c8};
   localparam logic [8:0] VSYNC_START [4] = '{9'd16, 9'd16, 9'd300, 9'd300};
   localparam logic [8:0] VSYNC_LINES     = 9'd3;

   // register addresses handled by the interrupt unit
   localparam logic [5:0] ADDR_CTRL1      = 6'h11;
   localparam logic [5:0] ADDR_RASTER     = 6'h12;
   localparam logic [5:0] ADDR_IRQ_STATUS = 6'h19;
   localparam logic [5:0] ADDR_IRQ_ENABLE = 6'h1a;

   typedef struct packed {
      logic       pixel;
      logic       phi;
      logic       phase_start;
      logic [6:0] cycle_num;
   } timing_t;

   typedef struct packed {
      logic [9:0] raster_x;
      logic [9:0] xpos;
      logic [8:0] raster_line;
   } position_t;

   // control register 1 layout
   typedef struct packed {
      logic       raster8;
      logic       ecm;
      logic       bmm;
      logic       den;
      logic       rsel;
      logic [2:0] yscroll;
   } ctrl1_t;

   // 0x11 decodes as ctrl1, 0x12 is the plain raster compare byte
   typedef union packed {
      ctrl1_t     ctrl1;
      logic [7:0] raw;
   } reg_data_u;

   typedef struct packed {
      logic       strobe;
      logic [5:0] addr;
      reg_data_u  data;
   } reg_wr_t;

endpackage

//--- source/vic_raster_top.sv
`timescale 1ns/1ps

module vic_raster_top import vic_pkg::*; (
   input  logic       clk_dot4x,
   input  logic       rst,
   input  chip_t      chip,
   input  reg_wr_t    reg_wr,
   output logic       pixel_strobe,
   output position_t  pos,
   output logic [9:0] sprite_raster_x,
   output logic [8:0] raster_line_d,
   output logic       irq,
   output logic       hsync,
   output logic       vsync
);

   timing_t timing;

   dot_timing i_dot_timing (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .timing    (timing)
   );

   assign pixel_strobe = timing.pixel;

   raster i_raster (
      .clk_dot4x       (clk_dot4x),
      .rst             (rst),
      .chip            (chip),
      .timing          (timing),
      .pos             (pos),
      .sprite_raster_x (sprite_raster_x),
      .raster_line_d   (raster_line_d)
   );

   // both consumers read the same position
   raster_irq i_raster_irq (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .pos       (pos),
      .reg_wr    (reg_wr),
      .irq       (irq)
   );

   video_sync i_video_sync (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .pos       (pos),
      .hsync     (hsync),
      .vsync     (vsync)
   );

endmodule

//--- source/video_sync.sv
`timescale 1ns/1ps

module video_sync import vic_pkg::*; (
   input  logic      clk_dot4x,
   input  logic      rst,
   input  chip_t     chip,
   input  position_t pos,
   output logic      hsync,
   output logic      vsync
);

   logic [9:0] hs_start;
   logic [9:0] hs_end;
   logic [8:0] vs_start;
   logic [8:0] vs_end;
   logic       hsync_next;
   logic       vsync_next;

   assign hs_start = HSYNC_START[chip];
   assign hs_end   = HSYNC_END[chip];
   assign vs_start = VSYNC_START[chip];
   assign vs_end   = vs_start + VSYNC_LINES;

   // hsync follows xpos, not raster_x, so the R8 hold region is seen as on hardware
   assign hsync_next = (pos.xpos >= hs_start) && (pos.xpos < hs_end);

   // vsync covers VSYNC_LINES whole lines
   assign vsync_next = (pos.raster_line >= vs_start) && (pos.raster_line < vs_end);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         hsync <= 1'b0;
         vsync <= 1'b0;
      end else begin
         hsync <= hsync_next;
         vsync <= vsync_next;
      end
   end

endmodule

//--- verilog.f
source/vic_pkg.sv
source/dot_timing.sv
source/raster.sv
source/raster_irq.sv
source/video_sync.sv
source/vic_raster_top.sv
sim/raster_checker.sv
sim/tb_vic_raster.sv
